// File: source/fdc_pkg.sv
package fdc_pkg;

   // Register layout served on the cartridge bus
   typedef enum logic [1:0] {
      MODEL_PHILIPS  = 2'd0,
      MODEL_NATIONAL = 2'd1
   } fdc_model_t;

   // Drive selected by the control latch
   typedef enum logic [1:0] {
      DRIVE_NONE = 2'd0,
      DRIVE_A    = 2'd1,
      DRIVE_B    = 2'd2
   } drive_t;

   // One control byte, read through the layout that wrote it
   typedef union packed {
      struct packed {
         logic       motor;
         logic [4:0] spare;
         logic [1:0] drive_sel;
      } philips;
      struct packed {
         logic [3:0] spare;
         logic       motor;
         logic       side;
         logic [1:0] drive_code;
      } national;
   } ctrl_byte_u;

   // Command groups recognized from the upper nibble of the command byte
   typedef enum logic [2:0] {
      CMD_RESTORE   = 3'd0,
      CMD_SEEK      = 3'd1,
      CMD_STEP_IN   = 3'd2,
      CMD_STEP_OUT  = 3'd3,
      CMD_FORCE_INT = 3'd4,
      CMD_OTHER     = 3'd5
   } cmd_t;

   // Controller register indices on address bits 1..0
   localparam logic [1:0] WD_REG_STATUS_CMD = 2'd0;
   localparam logic [1:0] WD_REG_TRACK      = 2'd1;
   localparam logic [1:0] WD_REG_SECTOR     = 2'd2;
   localparam logic [1:0] WD_REG_DATA       = 2'd3;

   // Offsets of the extra ports inside the Philips window
   localparam logic [2:0] PHILIPS_SIDE_OFS   = 3'd4;
   localparam logic [2:0] PHILIPS_DRIVE_OFS  = 3'd5;
   localparam logic [2:0] PHILIPS_STATUS_OFS = 3'd7;

   // Upper address bits that mark each window at the top of the page
   localparam logic [10:0] PHILIPS_AREA_TAG  = 11'h7FF;
   localparam logic [6:0]  NATIONAL_AREA_TAG = 7'h7F;

   // Step timing in bus clock cycles
   localparam int unsigned STEP_PULSE_CYCLES  = 4;
   localparam int unsigned STEP_PERIOD_CYCLES = 32;
   localparam int unsigned RESTORE_LIMIT      = 255;

   // Bit 2 of the drive register always reads back as zero
   localparam logic [7:0] DRIVE_MASK = 8'hFB;

   // Sequencer state codes
   localparam logic [1:0] SEQ_IDLE  = 2'd0;
   localparam logic [1:0] SEQ_CHECK = 2'd1;
   localparam logic [1:0] SEQ_PULSE = 2'd2;
   localparam logic [1:0] SEQ_GAP   = 2'd3;

endpackage

// File: source/fdc_access_if.sv
`timescale 1ns/100ps

interface fdc_access_if;

   // Controller register window hit (address bit 2 low)
   logic       wd_sel;
   // Bus strobes, already qualified by cs, mreq and an area hit
   logic       rd;
   logic       wr;
   logic [2:0] reg_ofs;
   logic [7:0] wdata;
   // Area flags, qualified by cs and mreq
   logic       philips_area;
   logic       national_area;
   // Latch write strobes, each a single cycle
   logic       side_wr;
   logic       drive_wr;
   logic       national_ctrl_wr;
   // National status port read
   logic       status_rd;

   modport decode (
      output wd_sel, rd, wr, reg_ofs, wdata, philips_area, national_area,
      output side_wr, drive_wr, national_ctrl_wr, status_rd
   );

   modport core (
      input wd_sel, rd, wr, reg_ofs, wdata
   );

   modport latch (
      input side_wr, drive_wr, national_ctrl_wr, wdata
   );

   modport mux (
      input wd_sel, rd, reg_ofs, philips_area, national_area, status_rd
   );

endinterface

// File: source/fdc_bus_decode.sv
`timescale 1ns/100ps

module fdc_bus_decode
   import fdc_pkg::*;
(
   input  logic              cpu_bus,
   input  fdc_model_t        model,
   input  logic              cs,
   input  logic              mreq,
   input  logic              rd,
   input  logic              wr,
   input  logic [13:0]       addr,
   input  logic [7:0]        wdata,
   fdc_access_if.decode      acc
);

   logic philips_hit;
   logic national_hit;
   logic bus_cycle;
   logic device_cs;

   // Philips keeps its eight registers in the last 8 bytes of the page
   assign philips_hit  = (addr[13:3] == PHILIPS_AREA_TAG) && (model == MODEL_PHILIPS);
   // National decodes a 128 byte window and mirrors its ports inside it
   assign national_hit = (addr[13:7] == NATIONAL_AREA_TAG) && (model == MODEL_NATIONAL);

   assign bus_cycle = cs && mreq;
   assign device_cs = bus_cycle && (philips_hit || national_hit);

   assign acc.philips_area  = bus_cycle && philips_hit;
   assign acc.national_area = bus_cycle && national_hit;

   // The controller owns the lower half of either window
   assign acc.wd_sel  = device_cs && !addr[2];
   assign acc.rd      = device_cs && rd;
   assign acc.wr      = device_cs && wr;
   assign acc.reg_ofs = addr[2:0];
   assign acc.wdata   = wdata;

   // Philips side and drive latches sit at fixed offsets in the upper half
   assign acc.side_wr  = acc.philips_area && wr && (addr[2:0] == PHILIPS_SIDE_OFS);
   assign acc.drive_wr = acc.philips_area && wr && (addr[2:0] == PHILIPS_DRIVE_OFS);

   // National has a single control byte for writes and a status byte for reads
   // anywhere in the upper half
   assign acc.national_ctrl_wr = acc.national_area && wr && addr[2];
   assign acc.status_rd        = acc.national_area && rd && addr[2];

   // The CPU never reads and writes in the same cycle
   rd_wr_exclusive_a: assert property (@(posedge cpu_bus) !(rd && wr))
      else $error("rd and wr both high on the CPU bus");

endmodule

// File: source/fdc_drive_latch.sv
`timescale 1ns/100ps

module fdc_drive_latch
   import fdc_pkg::*;
(
   input  logic         cpu_bus,
   input  logic         arst_n,
   fdc_access_if.latch  acc,
   output logic [7:0]   side_reg,
   output logic [7:0]   drive_reg,
   output drive_t       drive,
   output logic         side,
   output logic         motor
);

   ctrl_byte_u ctrl;
   drive_t     philips_drive;
   drive_t     national_drive;

   // The same data byte, seen through either layout
   assign ctrl = acc.wdata;

   // Philips drive code, where codes 0 and 2 both pick drive A
   always_comb begin
      case (ctrl.philips.drive_sel)
         2'd0, 2'd2: philips_drive = DRIVE_A;
         2'd1:       philips_drive = DRIVE_B;
         default:    philips_drive = DRIVE_NONE;
      endcase
   end

   // National drive code is one-hot in the low two bits
   always_comb begin
      case (ctrl.national.drive_code)
         2'd1:    national_drive = DRIVE_A;
         2'd2:    national_drive = DRIVE_B;
         default: national_drive = DRIVE_NONE;
      endcase
   end

   always_ff @(posedge cpu_bus or negedge arst_n) begin
      if (!arst_n) begin
         side_reg  <= 8'd0;
         drive_reg <= 8'd0;
         drive     <= DRIVE_A;
         side      <= 1'b0;
         motor     <= 1'b0;
      end else begin
         // Philips side register, only bit 0 reaches the drive
         if (acc.side_wr) begin
            side_reg <= acc.wdata;
            side     <= acc.wdata[0];
         end
         // Philips drive register keeps the whole byte for readback
         if (acc.drive_wr) begin
            drive_reg <= acc.wdata;
            drive     <= philips_drive;
            motor     <= ctrl.philips.motor;
         end
         // National packs drive, side and motor into one byte
         if (acc.national_ctrl_wr) begin
            drive <= national_drive;
            side  <= ctrl.national.side;
            motor <= ctrl.national.motor;
         end
      end
   end

endmodule

// File: source/fdc_command_core.sv
`timescale 1ns/100ps

module fdc_command_core
   import fdc_pkg::*;
(
   input  logic        cpu_bus,
   input  logic        arst_n,
   fdc_access_if.core  acc,
   input  logic        track0_n,
   input  logic        ready_n,
   input  logic        wprot_n,
   output logic        step_n,
   output logic        dir_n,
   output logic [7:0]  wd_rdata,
   output logic        intrq
);

   // Group a command byte by its upper nibble, as on the WD279x
   function automatic cmd_t classify(input logic [3:0] op);
      casez (op)
         4'b0000: classify = CMD_RESTORE;
         4'b0001: classify = CMD_SEEK;
         4'b010?: classify = CMD_STEP_IN;
         4'b011?: classify = CMD_STEP_OUT;
         4'b1101: classify = CMD_FORCE_INT;
         default: classify = CMD_OTHER;
      endcase
   endfunction

   logic [1:0]  seq_state;
   cmd_t        cmd_q;
   cmd_t        cmd_new;
   logic [7:0]  track_reg;
   logic [7:0]  sector_reg;
   logic [7:0]  data_reg;
   logic [7:0]  status;
   logic [7:0]  step_cnt;
   logic [$clog2(STEP_PERIOD_CYCLES)-1:0] timer;
   logic [1:0]  reg_idx;
   logic        busy;
   logic        seek_err;
   logic        step_q;
   logic        dir_in;
   logic        cmd_wr;
   logic        status_rd;
   logic        seek_in;
   logic        check_step;
   logic        step_dir_in;

   assign reg_idx   = acc.reg_ofs[1:0];
   assign cmd_wr    = acc.wr && acc.wd_sel && (reg_idx == WD_REG_STATUS_CMD);
   assign status_rd = acc.rd && acc.wd_sel && (reg_idx == WD_REG_STATUS_CMD);
   assign cmd_new   = classify(acc.wdata[7:4]);
   assign busy      = (seq_state != SEQ_IDLE);
   assign seek_in   = (data_reg > track_reg);
   assign step_n    = !step_q;
   assign dir_n     = !dir_in;

   // Type I status: not ready, write protect, seek error, track 0 and busy
   assign status = {ready_n, !wprot_n, 1'b0, seek_err, 1'b0, !track0_n, 1'b0, busy};

   always_comb begin
      case (reg_idx)
         WD_REG_STATUS_CMD: wd_rdata = status;
         WD_REG_TRACK:      wd_rdata = track_reg;
         WD_REG_SECTOR:     wd_rdata = sector_reg;
         default:           wd_rdata = data_reg;
      endcase
   end

   // Decide between another step and the end of the command
   always_comb begin
      check_step  = 1'b0;
      step_dir_in = 1'b0;
      case (cmd_q)
         CMD_RESTORE: begin
            check_step = track0_n && (step_cnt != RESTORE_LIMIT);
         end
         CMD_SEEK: begin
            check_step  = (track_reg != data_reg);
            step_dir_in = seek_in;
         end
         CMD_STEP_IN: begin
            check_step  = (step_cnt == 8'd0);
            step_dir_in = 1'b1;
         end
         CMD_STEP_OUT: begin
            check_step = (step_cnt == 8'd0);
         end
         default: ;
      endcase
   end

   always_ff @(posedge cpu_bus or negedge arst_n) begin
      if (!arst_n) begin
         seq_state  <= SEQ_IDLE;
         cmd_q      <= CMD_OTHER;
         track_reg  <= 8'd0;
         sector_reg <= 8'd0;
         data_reg   <= 8'd0;
         step_cnt   <= 8'd0;
         timer      <= '0;
         seek_err   <= 1'b0;
         step_q     <= 1'b0;
         dir_in     <= 1'b0;
         intrq      <= 1'b0;
      end else begin
         // Reading status acknowledges the interrupt
         if (status_rd) begin
            intrq <= 1'b0;
         end
         if (acc.wr && acc.wd_sel) begin
            case (reg_idx)
               WD_REG_TRACK:  track_reg  <= acc.wdata;
               WD_REG_SECTOR: sector_reg <= acc.wdata;
               WD_REG_DATA:   data_reg   <= acc.wdata;
               default: ;
            endcase
         end
         case (seq_state)
            SEQ_CHECK: begin
               if (check_step) begin
                  // Seek and step move the track register with the head
                  if (cmd_q != CMD_RESTORE) begin
                     track_reg <= step_dir_in ? track_reg + 8'd1 : track_reg - 8'd1;
                  end
                  step_q    <= 1'b1;
                  dir_in    <= step_dir_in;
                  timer     <= '0;
                  step_cnt  <= step_cnt + 8'd1;
                  seq_state <= SEQ_PULSE;
               end else begin
                  if (cmd_q == CMD_RESTORE) begin
                     if (!track0_n) begin
                        track_reg <= 8'd0;
                     end else begin
                        seek_err <= 1'b1;
                     end
                  end
                  intrq     <= 1'b1;
                  seq_state <= SEQ_IDLE;
               end
            end
            SEQ_PULSE: begin
               timer <= timer + 1'b1;
               if (timer == STEP_PULSE_CYCLES - 1) begin
                  step_q    <= 1'b0;
                  seq_state <= SEQ_GAP;
               end
            end
            SEQ_GAP: begin
               // Leave one cycle for the check so steps start a full period apart
               timer <= timer + 1'b1;
               if (timer == STEP_PERIOD_CYCLES - 2) begin
                  seq_state <= SEQ_CHECK;
               end
            end
            default: ;
         endcase
         // Handled last so force interrupt wins over the running sequencer
         if (cmd_wr) begin
            if (cmd_new == CMD_FORCE_INT) begin
               step_q    <= 1'b0;
               intrq     <= 1'b1;
               seq_state <= SEQ_IDLE;
            end else if (!busy && cmd_new != CMD_OTHER) begin
               cmd_q     <= cmd_new;
               step_cnt  <= 8'd0;
               seek_err  <= 1'b0;
               intrq     <= 1'b0;
               seq_state <= SEQ_CHECK;
            end
         end
      end
   end

   // The head only moves while a command runs
   step_when_busy_a: assert property (@(posedge cpu_bus) disable iff (!arst_n)
      !step_n |-> busy)
      else $error("step pulse outside a command");

endmodule

// File: source/fdc_read_mux.sv
`timescale 1ns/100ps

module fdc_read_mux
   import fdc_pkg::*;
(
   fdc_access_if.mux  acc,
   input  logic [7:0] wd_rdata,
   input  logic [7:0] side_reg,
   input  logic [7:0] drive_reg,
   input  logic       intrq,
   output logic [7:0] rdata,
   output logic       data_oe
);

   always_comb begin
      rdata   = 8'hFF;
      data_oe = 1'b0;
      if (acc.rd && acc.wd_sel) begin
         // Controller registers in either layout
         rdata   = wd_rdata;
         data_oe = 1'b1;
      end else if (acc.rd && acc.philips_area) begin
         case (acc.reg_ofs)
            PHILIPS_SIDE_OFS: begin
               rdata   = side_reg;
               data_oe = 1'b1;
            end
            PHILIPS_DRIVE_OFS: begin
               rdata   = drive_reg & DRIVE_MASK;
               data_oe = 1'b1;
            end
            PHILIPS_STATUS_OFS: begin
               // Without sector transfers DRQ never rises, so not-DRQ in bit 7 stays high
               rdata   = {1'b1, !intrq, 6'b111111};
               data_oe = 1'b1;
            end
            // Offset 6 is left floating on the bus
            default: ;
         endcase
      end else if (acc.status_rd) begin
         // National status has active high interrupt in bit 7 and not-DRQ in bit 6
         rdata   = {intrq, 1'b1, 6'b111111};
         data_oe = 1'b1;
      end
   end

endmodule

// File: source/fdc_top.sv
`timescale 1ns/100ps

module fdc_top
   import fdc_pkg::*;
(
   input  logic        cpu_bus,
   input  logic        arst_n,
   input  fdc_model_t  model,
   input  logic        cs,
   input  logic        mreq,
   input  logic        rd,
   input  logic        wr,
   input  logic [13:0] addr,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata,
   output logic        data_oe,
   input  logic        track0_n,
   input  logic        ready_n,
   input  logic        wprot_n,
   output logic        step_n,
   output logic        dir_n,
   output logic        motor_n,
   output logic        side_n
);

   fdc_access_if acc_if ();

   logic [7:0] wd_rdata;
   logic [7:0] side_reg;
   logic [7:0] drive_reg;
   logic       intrq;
   drive_t     drive;
   logic       side;
   logic       motor;

   fdc_bus_decode decode_i (
      .cpu_bus (cpu_bus),
      .model   (model),
      .cs      (cs),
      .mreq    (mreq),
      .rd      (rd),
      .wr      (wr),
      .addr    (addr),
      .wdata   (wdata),
      .acc     (acc_if.decode)
   );

   fdc_drive_latch latch_i (
      .cpu_bus   (cpu_bus),
      .arst_n    (arst_n),
      .acc       (acc_if.latch),
      .side_reg  (side_reg),
      .drive_reg (drive_reg),
      .drive     (drive),
      .side      (side),
      .motor     (motor)
   );

   fdc_command_core core_i (
      .cpu_bus  (cpu_bus),
      .arst_n   (arst_n),
      .acc      (acc_if.core),
      .track0_n (track0_n),
      .ready_n  (ready_n),
      .wprot_n  (wprot_n),
      .step_n   (step_n),
      .dir_n    (dir_n),
      .wd_rdata (wd_rdata),
      .intrq    (intrq)
   );

   fdc_read_mux mux_i (
      .acc       (acc_if.mux),
      .wd_rdata  (wd_rdata),
      .side_reg  (side_reg),
      .drive_reg (drive_reg),
      .intrq     (intrq),
      .rdata     (rdata),
      .data_oe   (data_oe)
   );

   // Only drive A is wired to a motor line
   assign motor_n = !(motor && drive == DRIVE_A);
   assign side_n  = !side;

endmodule

// File: testbench/fdc_tb.sv
`timescale 1ns/100ps

module fdc_tb
   import fdc_pkg::*;
();

   // Philips window sits in the last 8 bytes of the page, National in the last 128
   localparam logic [13:0] PH_BASE = 14'h3FF8;
   localparam logic [13:0] NS_BASE = 14'h3F80;
   localparam logic [13:0] NS_CTRL = 14'h3F84;
   localparam int unsigned SEED = 48816;
   // Longest run is two seeks of up to 48 tracks, a few single steps, a restore of up to
   // 48 tracks and one of 255 steps, about 400 steps of 32 cycles plus bus traffic
   localparam int unsigned TIMEOUT_CYCLES = 40000;

   logic        cpu_bus = 1'b0;
   logic        arst_n;
   fdc_model_t  model;
   logic        cs;
   logic        mreq;
   logic        rd;
   logic        wr;
   logic [13:0] addr;
   logic [7:0]  wdata;
   logic [7:0]  rdata;
   logic        data_oe;
   logic        track0_n = 1'b0;
   logic        ready_n;
   logic        wprot_n;
   logic        step_n;
   logic        dir_n;
   logic        motor_n;
   logic        side_n;

   // Head position model of the drive
   int          head_pos = 0;
   int          steps_in = 0;
   int          steps_out = 0;
   logic        step_prev = 1'b1;
   logic        stuck_t0 = 1'b0;
   int unsigned cycle_count = 0;

   always #4 cpu_bus = ~cpu_bus;

   fdc_top dut_i (
      .cpu_bus  (cpu_bus),
      .arst_n   (arst_n),
      .model    (model),
      .cs       (cs),
      .mreq     (mreq),
      .rd       (rd),
      .wr       (wr),
      .addr     (addr),
      .wdata    (wdata),
      .rdata    (rdata),
      .data_oe  (data_oe),
      .track0_n (track0_n),
      .ready_n  (ready_n),
      .wprot_n  (wprot_n),
      .step_n   (step_n),
      .dir_n    (dir_n),
      .motor_n  (motor_n),
      .side_n   (side_n)
   );

   // The head moves on the falling edge of step_n, inward while dir_n is low
   always @(posedge cpu_bus) begin
      step_prev <= step_n;
      if (step_prev && !step_n) begin
         if (!dir_n) begin
            head_pos <= head_pos + 1;
            steps_in <= steps_in + 1;
         end else begin
            steps_out <= steps_out + 1;
            // The carriage stops at the outer end
            if (head_pos > 0) begin
               head_pos <= head_pos - 1;
            end
         end
      end
      // Track 0 sensor, or a broken sensor that never reports it
      track0_n <= stuck_t0 || (head_pos != 0);
   end

   always @(posedge cpu_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT never finished a command", cycle_count);
         $display("Checks failed");
         $fatal(1, "simulation timeout");
      end
   end

   task automatic check(input logic [31:0] got, input logic [31:0] expected,
                        input string msg);
      if (got !== expected) begin
         $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, got, expected);
         $display("Checks failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // One write cycle, captured by the DUT on the second edge
   task automatic bus_write(input logic [13:0] a, input logic [7:0] d);
      @(posedge cpu_bus);
      cs    <= 1'b1;
      mreq  <= 1'b1;
      wr    <= 1'b1;
      addr  <= a;
      wdata <= d;
      @(posedge cpu_bus);
      cs    <= 1'b0;
      mreq  <= 1'b0;
      wr    <= 1'b0;
   endtask

   // Read data is combinational, so it is sampled in the middle of the cycle
   task automatic bus_read_raw(input logic [13:0] a, input logic cs_v, input logic mreq_v,
                               output logic [7:0] d, output logic oe);
      @(posedge cpu_bus);
      cs   <= cs_v;
      mreq <= mreq_v;
      rd   <= 1'b1;
      addr <= a;
      @(negedge cpu_bus);
      d  = rdata;
      oe = data_oe;
      @(posedge cpu_bus);
      cs   <= 1'b0;
      mreq <= 1'b0;
      rd   <= 1'b0;
   endtask

   task automatic read_expect(input logic [13:0] a, input logic [7:0] expected,
                              input string msg);
      logic [7:0] d;
      logic       oe;
      bus_read_raw(a, 1'b1, 1'b1, d, oe);
      check(oe, 1'b1, {msg, " data_oe"});
      check(d, expected, msg);
   endtask

   // Nothing answers, so the bus is left at its pull-up value
   task automatic read_floating(input logic [13:0] a, input logic cs_v, input logic mreq_v,
                                input string msg);
      logic [7:0] d;
      logic       oe;
      bus_read_raw(a, cs_v, mreq_v, d, oe);
      check(oe, 1'b0, {msg, " data_oe"});
      check(d, 8'hFF, msg);
   endtask

   task automatic check_pins(input logic exp_motor_n, input logic exp_side_n,
                             input string msg);
      @(negedge cpu_bus);
      check(motor_n, exp_motor_n, {msg, " motor_n"});
      check(side_n, exp_side_n, {msg, " side_n"});
   endtask

   task automatic set_model(input fdc_model_t m);
      @(posedge cpu_bus);
      model <= m;
   endtask

   // Commands go through the Philips window and set busy on the next cycle
   task automatic run_command(input logic [7:0] cmd);
      logic [7:0] d;
      logic       oe;
      bus_write(PH_BASE + WD_REG_STATUS_CMD, cmd);
      bus_read_raw(PH_BASE + WD_REG_STATUS_CMD, 1'b1, 1'b1, d, oe);
      check(d[0], 1'b1, "busy after command write");
   endtask

   // Poll the Philips status port until intrq, then acknowledge it
   task automatic wait_done(output logic [7:0] status);
      logic [7:0] d;
      logic       oe;
      d = 8'hFF;
      while (d[6]) begin
         bus_read_raw(PH_BASE + PHILIPS_STATUS_OFS, 1'b1, 1'b1, d, oe);
      end
      // DRQ stays inactive, so only the interrupt bit is low
      check(d, 8'hBF, "status port at interrupt");
      bus_read_raw(PH_BASE + WD_REG_STATUS_CMD, 1'b1, 1'b1, status, oe);
      check(status[0], 1'b0, "busy clear at interrupt");
      read_expect(PH_BASE + PHILIPS_STATUS_OFS, 8'hFF, "intrq cleared by status read");
   endtask

   task automatic seek_to(input int target);
      int         start;
      int         in0;
      int         out0;
      logic [7:0] st;
      start = head_pos;
      in0   = steps_in;
      out0  = steps_out;
      bus_write(PH_BASE + WD_REG_DATA, target[7:0]);
      run_command(8'h10);
      wait_done(st);
      check(steps_in - in0, (target > start) ? target - start : 0, "inward seek steps");
      check(steps_out - out0, (target < start) ? start - target : 0, "outward seek steps");
      check(head_pos, target, "head position after seek");
      read_expect(PH_BASE + WD_REG_TRACK, target[7:0], "track after seek");
   endtask

   task automatic step_once(input logic [7:0] cmd, input int delta);
      int         start;
      logic [7:0] st;
      start = head_pos;
      run_command(cmd);
      wait_done(st);
      check(head_pos, start + delta, "head position after step");
      read_expect(PH_BASE + WD_REG_TRACK, head_pos[7:0], "track after step");
   endtask

   task automatic test_reset();
      @(negedge cpu_bus);
      check(data_oe, 1'b0, "idle data_oe");
      check(rdata, 8'hFF, "idle rdata");
      check(step_n, 1'b1, "step_n after reset");
      check(motor_n, 1'b1, "motor_n after reset");
      check(side_n, 1'b1, "side_n after reset");
      read_expect(PH_BASE + PHILIPS_SIDE_OFS, 8'h00, "side register after reset");
      read_expect(PH_BASE + PHILIPS_DRIVE_OFS, 8'h00, "drive register after reset");
      // Head rests on track 0, so only that status bit is set
      read_expect(PH_BASE + WD_REG_STATUS_CMD, 8'h04, "status after reset");
      for (int r = 1; r < 4; r++) begin
         read_expect(PH_BASE + r[13:0], 8'h00, "controller register after reset");
      end
   endtask

   task automatic test_philips_latch();
      logic [7:0] side_b;
      logic [7:0] drv_b;
      for (int i = 0; i < 8; i++) begin
         side_b = $urandom;
         bus_write(PH_BASE + PHILIPS_SIDE_OFS, side_b);
         read_expect(PH_BASE + PHILIPS_SIDE_OFS, side_b, "side register readback");
         // Cycle through every drive code with and without the motor bit
         drv_b      = $urandom;
         drv_b[1:0] = i[1:0];
         drv_b[7]   = i[2];
         bus_write(PH_BASE + PHILIPS_DRIVE_OFS, drv_b);
         read_expect(PH_BASE + PHILIPS_DRIVE_OFS, drv_b & DRIVE_MASK, "drive register readback");
         check_pins(!(drv_b[7] && (drv_b[1:0] == 2'd0 || drv_b[1:0] == 2'd2)), !side_b[0],
                    "Philips latch");
      end
   endtask

   task automatic test_national_ctrl();
      logic [7:0] b;
      set_model(MODEL_NATIONAL);
      for (int code = 0; code < 4; code++) begin
         for (int sm = 0; sm < 4; sm++) begin
            b      = $urandom;
            b[1:0] = code[1:0];
            b[2]   = sm[0];
            b[3]   = sm[1];
            bus_write(NS_CTRL, b);
            // Only code 1 selects drive A, the one with a motor line
            check_pins(!(b[3] && code == 1), !b[2], "National control");
         end
      end
      // No command has run, so intrq is clear and not-DRQ is set
      read_expect(NS_CTRL, {1'b0, 1'b1, 6'b111111}, "National status port");
      read_expect(14'h3FFC, {1'b0, 1'b1, 6'b111111}, "National status port mirror");
      // A force interrupt while idle raises intrq in bit 7 of the status port
      bus_write(NS_BASE + WD_REG_STATUS_CMD, 8'hD0);
      read_expect(NS_CTRL, {1'b1, 1'b1, 6'b111111}, "National status port with intrq");
      read_expect(NS_BASE + WD_REG_STATUS_CMD, 8'h04, "controller status in National window");
      read_expect(NS_CTRL, {1'b0, 1'b1, 6'b111111}, "National status port after status read");
   endtask

   task automatic test_registers();
      logic [7:0]  v;
      logic [7:0]  track_v;
      logic [13:0] base;
      track_v = 8'h00;
      for (int m = 0; m < 2; m++) begin
         set_model(m == 0 ? MODEL_PHILIPS : MODEL_NATIONAL);
         base = (m == 0) ? PH_BASE : NS_BASE;
         for (int r = 1; r < 4; r++) begin
            v = $urandom;
            if (r == WD_REG_TRACK) begin
               track_v = v;
            end
            bus_write(base + r[13:0], v);
            read_expect(base + r[13:0], v, "controller register readback");
         end
      end
      read_floating(14'h3F7F, 1'b1, 1'b1, "below National window");
      set_model(MODEL_PHILIPS);
      // A write into the National window must not reach the track register
      bus_write(NS_BASE + WD_REG_TRACK, ~track_v);
      read_expect(PH_BASE + WD_REG_TRACK, track_v, "track after wrong model write");
      read_floating(NS_BASE + WD_REG_TRACK, 1'b1, 1'b1, "National address in Philips mode");
      read_floating(PH_BASE - 14'd8, 1'b1, 1'b1, "below Philips window");
      read_floating(PH_BASE + 14'd6, 1'b1, 1'b1, "Philips offset 6");
      read_floating(PH_BASE + WD_REG_TRACK, 1'b1, 1'b0, "mreq low");
      read_floating(PH_BASE + WD_REG_TRACK, 1'b0, 1'b1, "cs low");
   endtask

   task automatic test_seek_step();
      int t;
      bus_write(PH_BASE + WD_REG_TRACK, head_pos[7:0]);
      t = $urandom_range(48, 8);
      seek_to(t);
      seek_to($urandom_range(t - 1, 1));
      step_once(8'h40, 1);
      step_once(8'h60, -1);
   endtask

   task automatic test_restore();
      int         out0;
      int         start;
      logic [7:0] st;
      start = head_pos;
      out0  = steps_out;
      run_command(8'h00);
      wait_done(st);
      check(steps_out - out0, start, "restore steps");
      check(head_pos, 0, "head position after restore");
      read_expect(PH_BASE + WD_REG_TRACK, 8'h00, "track after restore");
      check(st, 8'h04, "status after restore");
      // With a dead track 0 sensor the restore gives up after the step limit
      stuck_t0 <= 1'b1;
      @(posedge cpu_bus);
      @(posedge cpu_bus);
      out0 = steps_out;
      run_command(8'h00);
      wait_done(st);
      check(steps_out - out0, RESTORE_LIMIT, "restore steps without track 0");
      check(st, 8'h10, "seek error status");
      stuck_t0 <= 1'b0;
   endtask

   task automatic test_force_int();
      int         in0;
      logic [7:0] d;
      logic       oe;
      bus_write(PH_BASE + WD_REG_TRACK, head_pos[7:0]);
      bus_write(PH_BASE + WD_REG_DATA, 8'd100);
      in0 = steps_in;
      run_command(8'h10);
      while ((steps_in - in0) < 2) begin
         @(posedge cpu_bus);
      end
      bus_write(PH_BASE + WD_REG_STATUS_CMD, 8'hD0);
      read_expect(PH_BASE + PHILIPS_STATUS_OFS, 8'hBF, "interrupt after force interrupt");
      bus_read_raw(PH_BASE + WD_REG_STATUS_CMD, 1'b1, 1'b1, d, oe);
      check(d[0], 1'b0, "busy after force interrupt");
      check(step_n, 1'b1, "step_n after force interrupt");
      read_expect(PH_BASE + WD_REG_TRACK, head_pos[7:0], "track after force interrupt");
   endtask

   initial begin
      void'($urandom(SEED));
      arst_n  = 1'b0;
      model   = MODEL_PHILIPS;
      cs      = 1'b0;
      mreq    = 1'b0;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = 14'd0;
      wdata   = 8'd0;
      ready_n = 1'b0;
      wprot_n = 1'b1;
      repeat (3) @(posedge cpu_bus);
      arst_n <= 1'b1;
      test_reset();
      test_philips_latch();
      test_national_ctrl();
      test_registers();
      test_seek_step();
      test_restore();
      test_force_int();
      $display("All checks passed");
      $finish;
   end

endmodule

// File: flist.f
source/fdc_pkg.sv
source/fdc_access_if.sv
source/fdc_bus_decode.sv
source/fdc_drive_latch.sv
source/fdc_command_core.sv
source/fdc_read_mux.sv
source/fdc_top.sv
testbench/fdc_tb.sv

// File: Makefile
# Verilator build and run for the floppy disk interface testbench

VERILATOR       ?= verilator
TOP             ?= fdc_tb
FLIST           ?= flist.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG        ?= Checks failed
PASS_MSG        ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
